// File: Bender.yml
package:
  name: wro_shim

export_include_dirs:
  - rtl

sources:
  - rtl/wro_pkg.sv
  - rtl/wro_req_fifo.sv
  - rtl/wro_filter_cam.sv
  - rtl/wro_tag_heap.sv
  - rtl/wro_order_ctrl.sv
  - rtl/wro_shim.sv
  - target: test
    files:
      - tests/wro_shim_chk.sv
      - tests/wro_shim_tb.sv

// File: rtl/wro_consts.svh
// Sizing constants. Mdata must be wider than either tag and the buffer deeper than the margin
`ifndef WRO_CONSTS_SVH
`define WRO_CONSTS_SVH

// Request address and client mdata widths
`define WRO_ADDR_BITS 32
`define WRO_MDATA_BITS 16

// Width of the hashed address kept in the conflict filters
// Fewer bits save area but raise the rate of false conflicts
`define WRO_HASH_BITS 9

// Tags in flight per channel, reads usually need more for full bandwidth
`define WRO_RD_TAGS 80
`define WRO_WR_TAGS 48

// Input buffer depth and the free-slot margin that raises almost_full
`define WRO_BUF_ENTRIES 8
`define WRO_BUF_ALMOST_FULL 2

`endif

// File: rtl/wro_filter_cam.sv
// Hash CAM indexed by tag. An index must be removed before it is inserted again
`timescale 1ns/1ps

module wro_filter_cam
    import wro_pkg::*;
#(
    parameter int N_BUCKETS = 64,
    parameter int N_TESTS   = 1
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  hash_t [N_TESTS-1:0]          test_hash,
    input  logic  [N_TESTS-1:0]          test_en,
    output logic  [N_TESTS-1:0]          test_hit,
    input  logic                         insert_en,
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  hash_t                        insert_hash,
    input  logic                         remove_en,
    input  logic [$clog2(N_BUCKETS)-1:0] remove_idx
);

    localparam int IDX_W = $clog2(N_BUCKETS);

    logic [N_BUCKETS-1:0] bucket_valid;
    hash_t                bucket_hash [N_BUCKETS];

    // Inserts are staged for one cycle before they land in a bucket
    // so the write side stays off the path of the issue decision
    logic                 pend_en;
    logic [IDX_W-1:0]     pend_idx;
    hash_t                pend_hash;

    // ====================
    // Test ports

    // Each test scans every bucket
    // The staged insert is compared too, it belongs to a request already issued
    always_comb
    begin
        for (int t = 0; t < N_TESTS; t++)
        begin
            test_hit[t] = pend_en && (pend_hash == test_hash[t]);
            for (int b = 0; b < N_BUCKETS; b++)
            begin
                test_hit[t] |= bucket_valid[b] && (bucket_hash[b] == test_hash[t]);
            end
            test_hit[t] &= test_en[t];
        end
    end

    // ====================
    // Bucket update

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bucket_valid <= '0;
            pend_en      <= 1'b0;
        end
        else
        begin
            pend_en <= insert_en;
            if (pend_en)
            begin
                bucket_valid[pend_idx] <= 1'b1;
            end
            // Remove comes last and wins if a response retires a staged tag
            if (remove_en)
            begin
                bucket_valid[remove_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        pend_idx  <= insert_idx;
        pend_hash <= insert_hash;
        if (pend_en)
        begin
            bucket_hash[pend_idx] <= pend_hash;
        end
    end

endmodule

// File: rtl/wro_order_ctrl.sv
// Issue control for the buffer head. Filter hits must come from the same cycle's head hashes
`timescale 1ns/1ps

module wro_order_ctrl
    import wro_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  req_pair_t head,
    input  logic      head_valid,
    output logic      pop,
    output logic      clear_head_rd,
    input  logic      fiu_almost_full,
    input  logic      rd_test_hit,
    input  logic [1:0] wr_test_hit,
    input  logic      rd_not_full,
    input  logic      wr_not_full,
    input  rd_tag_t   rd_alloc_idx,
    input  wr_tag_t   wr_alloc_idx,
    output logic      rd_alloc,
    output logic      wr_alloc,
    output rd_entry_t rd_alloc_data,
    output wr_entry_t wr_alloc_data,
    output hash_t     test_rd_hash,
    output hash_t     test_wr_hash,
    output logic      fiu_rd_valid,
    output addr_t     fiu_rd_addr,
    output mdata_t    fiu_rd_mdata,
    output logic      fiu_wr_valid,
    output addr_t     fiu_wr_addr,
    output mdata_t    fiu_wr_mdata
);

    logic rd_live;
    logic wr_live;
    logic same_addr;
    logic rd_blocked;
    logic wr_blocked;
    logic issue_pair;
    logic issue_rd_only;

    assign test_rd_hash = addr_hash(head.rd.addr);
    assign test_wr_hash = addr_hash(head.wr.addr);

    assign rd_live = head_valid && head.rd.valid;
    assign wr_live = head_valid && head.wr.valid;

    // Read and write of one pair to the same address cannot share a cycle
    assign same_addr = rd_live && wr_live && (head.rd.addr == head.wr.addr);

    // wr_test_hit[0] is the read checked against live writes
    // wr_test_hit[1] and rd_test_hit are the write checked against live writes and reads
    assign rd_blocked = rd_live &&
                        (fiu_almost_full || !rd_not_full ||
                         (head.rd.check_order && wr_test_hit[0]));
    assign wr_blocked = wr_live &&
                        (fiu_almost_full || !wr_not_full ||
                         (head.wr.check_order && (rd_test_hit || wr_test_hit[1])));

    // Lockstep issue, either channel blocked holds the whole pair
    assign issue_pair    = (rd_live || wr_live) && !rd_blocked && !wr_blocked && !same_addr;
    // On an address clash the read goes alone and the write stays at the head
    assign issue_rd_only = same_addr && !rd_blocked;

    assign pop           = issue_pair;
    assign clear_head_rd = issue_rd_only;
    assign rd_alloc      = issue_rd_only || (issue_pair && rd_live);
    assign wr_alloc      = issue_pair && wr_live;

    // The heaps keep the mdata bits that the tags overwrite
    assign rd_alloc_data.mdata = head.rd.mdata[$bits(rd_tag_t)-1:0];
    assign wr_alloc_data.mdata = head.wr.mdata[$bits(wr_tag_t)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fiu_rd_valid <= 1'b0;
            fiu_wr_valid <= 1'b0;
        end
        else
        begin
            fiu_rd_valid <= rd_alloc;
            fiu_wr_valid <= wr_alloc;
        end
    end

    // Tag goes in the low mdata bits, the upper bits pass unchanged
    always_ff @(posedge clk)
    begin
        fiu_rd_addr  <= head.rd.addr;
        fiu_rd_mdata <= {head.rd.mdata[$bits(mdata_t)-1:$bits(rd_tag_t)], rd_alloc_idx};
        fiu_wr_addr  <= head.wr.addr;
        fiu_wr_mdata <= {head.wr.mdata[$bits(mdata_t)-1:$bits(wr_tag_t)], wr_alloc_idx};
    end

endmodule

// File: rtl/wro_pkg.sv
// Shared types and the address hash. All widths are derived from wro_consts.svh
`include "wro_consts.svh"

package wro_pkg;

    typedef logic [`WRO_HASH_BITS-1:0]         hash_t;
    typedef logic [$clog2(`WRO_RD_TAGS)-1:0]   rd_tag_t;
    typedef logic [$clog2(`WRO_WR_TAGS)-1:0]   wr_tag_t;
    typedef logic [`WRO_ADDR_BITS-1:0]         addr_t;
    typedef logic [`WRO_MDATA_BITS-1:0]        mdata_t;

    // One channel of a client request
    typedef struct packed
    {
        logic   valid;
        logic   check_order;
        addr_t  addr;
        mdata_t mdata;
    } req_t;

    // Read and write requests that entered together travel as one buffer entry
    typedef struct packed
    {
        req_t rd;
        req_t wr;
    } req_pair_t;

    // Low mdata bits that the tag overwrites, saved per tag until the response
    typedef struct packed
    {
        rd_tag_t mdata;
    } rd_entry_t;

    typedef struct packed
    {
        wr_tag_t mdata;
    } wr_entry_t;

    localparam int HASH_SLICES = (`WRO_ADDR_BITS + `WRO_HASH_BITS - 1) / `WRO_HASH_BITS;

    // Fold the address by XOR of consecutive hash-wide slices, the top one zero padded
    function automatic hash_t addr_hash(input addr_t addr);
        logic [HASH_SLICES*`WRO_HASH_BITS-1:0] padded;
        hash_t h;
        padded = '0;
        padded[`WRO_ADDR_BITS-1:0] = addr;
        h = '0;
        for (int i = 0; i < HASH_SLICES; i++)
        begin
            h ^= padded[i*`WRO_HASH_BITS +: `WRO_HASH_BITS];
        end
        return h;
    endfunction

endpackage

// File: rtl/wro_req_fifo.sv
// Pair buffer with a power-of-two depth. A push into a full buffer is lost, so heed almost_full
`timescale 1ns/1ps
`include "wro_consts.svh"

module wro_req_fifo
    import wro_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  req_pair_t push_data,
    input  logic      pop,
    output req_pair_t head,
    output logic      head_valid,
    input  logic      clear_head_rd,
    output logic      almost_full
);

    localparam int DEPTH = `WRO_BUF_ENTRIES;
    localparam int PTR_W = $clog2(DEPTH);

    req_pair_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    // Set once the read half of the head has left on its own
    logic             head_rd_done;

    assign count_next = count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    assign head_valid = (count != '0);

    // The head is read straight from storage with the consumed read half masked off
    always_comb
    begin
        head = mem[rd_ptr];
        head.rd.valid = mem[rd_ptr].rd.valid && !head_rd_done;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            head_rd_done <= 1'b0;
            almost_full  <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count_next;
            // A new head always starts with its read half intact
            if (pop)
            begin
                head_rd_done <= 1'b0;
            end
            else if (clear_head_rd)
            begin
                head_rd_done <= 1'b1;
            end
            // Margin leaves room for the pairs already in flight from the client
            almost_full <= (count_next >= (PTR_W+1)'(DEPTH - `WRO_BUF_ALMOST_FULL));
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: rtl/wro_shim.sv
// Ordering shim top. The memory must return each response's mdata exactly as it was issued
`timescale 1ns/1ps
`include "wro_consts.svh"

module wro_shim
    import wro_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   rd_req_valid,
    input  addr_t  rd_req_addr,
    input  mdata_t rd_req_mdata,
    input  logic   rd_req_check_order,
    input  logic   wr_req_valid,
    input  addr_t  wr_req_addr,
    input  mdata_t wr_req_mdata,
    input  logic   wr_req_check_order,
    output logic   almost_full,
    output logic   rd_rsp_valid,
    output mdata_t rd_rsp_mdata,
    output logic   wr_rsp_valid,
    output mdata_t wr_rsp_mdata,
    output logic   fiu_rd_valid,
    output addr_t  fiu_rd_addr,
    output mdata_t fiu_rd_mdata,
    output logic   fiu_wr_valid,
    output addr_t  fiu_wr_addr,
    output mdata_t fiu_wr_mdata,
    input  logic   fiu_almost_full,
    input  logic   fiu_rd_rsp_valid,
    input  mdata_t fiu_rd_rsp_mdata,
    input  logic   fiu_wr_rsp_valid,
    input  mdata_t fiu_wr_rsp_mdata
);

    req_pair_t push_data;
    req_pair_t head;
    logic      head_valid;
    logic      pop;
    logic      clear_head_rd;
    hash_t     test_rd_hash;
    hash_t     test_wr_hash;
    logic      rd_test_hit;
    logic [1:0] wr_test_hit;
    logic      rd_alloc;
    logic      wr_alloc;
    rd_entry_t rd_alloc_data;
    wr_entry_t wr_alloc_data;
    rd_entry_t rd_saved;
    wr_entry_t wr_saved;
    rd_tag_t   rd_alloc_idx;
    wr_tag_t   wr_alloc_idx;
    logic      rd_not_full;
    logic      wr_not_full;
    rd_tag_t   rd_rsp_tag;
    wr_tag_t   wr_rsp_tag;
    // Upper response mdata waits one cycle for the heap read
    logic [$bits(mdata_t)-$bits(rd_tag_t)-1:0] rd_rsp_upper;
    logic [$bits(mdata_t)-$bits(wr_tag_t)-1:0] wr_rsp_upper;

    // ====================
    // Request side

    assign push_data = '{rd: '{rd_req_valid, rd_req_check_order, rd_req_addr, rd_req_mdata},
                         wr: '{wr_req_valid, wr_req_check_order, wr_req_addr, wr_req_mdata}};

    wro_req_fifo i_fifo (
        .clk, .reset, .push(rd_req_valid || wr_req_valid), .push_data, .pop,
        .head, .head_valid, .clear_head_rd, .almost_full
    );

    // Read filter holds live reads and is checked by the write
    wro_filter_cam #(.N_BUCKETS(`WRO_RD_TAGS), .N_TESTS(1)) i_rd_filter (
        .clk, .reset, .test_hash(test_wr_hash), .test_en(head.wr.valid),
        .test_hit(rd_test_hit), .insert_en(rd_alloc), .insert_idx(rd_alloc_idx),
        .insert_hash(test_rd_hash), .remove_en(fiu_rd_rsp_valid), .remove_idx(rd_rsp_tag)
    );

    // Write filter holds live writes and is checked by both halves
    wro_filter_cam #(.N_BUCKETS(`WRO_WR_TAGS), .N_TESTS(2)) i_wr_filter (
        .clk, .reset, .test_hash({test_wr_hash, test_rd_hash}),
        .test_en({head.wr.valid, head.rd.valid}), .test_hit(wr_test_hit),
        .insert_en(wr_alloc), .insert_idx(wr_alloc_idx), .insert_hash(test_wr_hash),
        .remove_en(fiu_wr_rsp_valid), .remove_idx(wr_rsp_tag)
    );

    wro_tag_heap #(.entry_t(rd_entry_t), .N_ENTRIES(`WRO_RD_TAGS)) i_rd_heap (
        .clk, .reset, .alloc(rd_alloc), .alloc_data(rd_alloc_data), .not_full(rd_not_full),
        .alloc_idx(rd_alloc_idx), .read_idx(rd_rsp_tag), .read_data(rd_saved),
        .free(fiu_rd_rsp_valid), .free_idx(rd_rsp_tag)
    );

    wro_tag_heap #(.entry_t(wr_entry_t), .N_ENTRIES(`WRO_WR_TAGS)) i_wr_heap (
        .clk, .reset, .alloc(wr_alloc), .alloc_data(wr_alloc_data), .not_full(wr_not_full),
        .alloc_idx(wr_alloc_idx), .read_idx(wr_rsp_tag), .read_data(wr_saved),
        .free(fiu_wr_rsp_valid), .free_idx(wr_rsp_tag)
    );

    wro_order_ctrl i_ctrl (
        .clk, .reset, .head, .head_valid, .pop, .clear_head_rd, .fiu_almost_full,
        .rd_test_hit, .wr_test_hit, .rd_not_full, .wr_not_full, .rd_alloc_idx, .wr_alloc_idx,
        .rd_alloc, .wr_alloc, .rd_alloc_data, .wr_alloc_data, .test_rd_hash, .test_wr_hash,
        .fiu_rd_valid, .fiu_rd_addr, .fiu_rd_mdata, .fiu_wr_valid, .fiu_wr_addr, .fiu_wr_mdata
    );

    // ====================
    // Response side

    // The tag rides in the low mdata bits of each response
    assign rd_rsp_tag = fiu_rd_rsp_mdata[$bits(rd_tag_t)-1:0];
    assign wr_rsp_tag = fiu_wr_rsp_mdata[$bits(wr_tag_t)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_rsp_valid <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= fiu_rd_rsp_valid;
            wr_rsp_valid <= fiu_wr_rsp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_rsp_upper <= fiu_rd_rsp_mdata[$bits(mdata_t)-1:$bits(rd_tag_t)];
        wr_rsp_upper <= fiu_wr_rsp_mdata[$bits(mdata_t)-1:$bits(wr_tag_t)];
    end

    // Saved low bits from the heap replace the tag
    assign rd_rsp_mdata = {rd_rsp_upper, rd_saved.mdata};
    assign wr_rsp_mdata = {wr_rsp_upper, wr_saved.mdata};

endmodule

// File: rtl/wro_tag_heap.sv
// Tag allocator with payload storage. Freeing an idle tag or allocating while full is not checked
`timescale 1ns/1ps

module wro_tag_heap #(
    parameter type entry_t   = logic,
    parameter int  N_ENTRIES = 16
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         alloc,
    input  entry_t                       alloc_data,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,
    input  logic [$clog2(N_ENTRIES)-1:0] read_idx,
    output entry_t                       read_data,
    input  logic                         free,
    input  logic [$clog2(N_ENTRIES)-1:0] free_idx
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    // One bit per tag, the free list is every tag whose bit is clear
    logic [N_ENTRIES-1:0] busy;
    entry_t               payload [N_ENTRIES];

    // ====================
    // Allocation

    // Offer the lowest free tag
    always_comb
    begin
        alloc_idx = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    assign not_full = ~&busy;

    // A tag freed at an edge is offered again right after it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= '0;
        end
        else
        begin
            if (alloc)
            begin
                busy[alloc_idx] <= 1'b1;
            end
            if (free)
            begin
                busy[free_idx] <= 1'b0;
            end
        end
    end

    // ====================
    // Payload

    // Read is registered, the data follows one cycle after read_idx
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            payload[alloc_idx] <= alloc_data;
        end
        read_data <= payload[read_idx];
    end

endmodule

// File: tests/wro_shim_chk.sv
// Port-level assertions bound into the shim. Valid-path checks are off while reset is high
`timescale 1ns/1ps

module wro_shim_chk (
    input logic clk,
    input logic reset,
    input logic almost_full,
    input logic rd_req_valid,
    input logic wr_req_valid,
    input logic rd_rsp_valid,
    input logic wr_rsp_valid,
    input logic fiu_rd_valid,
    input logic fiu_wr_valid,
    input logic fiu_almost_full
);

    // Number of assertion failures so far
    int unsigned error_count = 0;

    // Every valid and almost_full is low in the cycle after a reset edge
    reset_quiet: assert property (@(posedge clk)
        reset |=> !almost_full && !rd_rsp_valid && !wr_rsp_valid && !fiu_rd_valid && !fiu_wr_valid)
        else begin error_count++; $error("Outputs active right after reset"); end

    // Occupancy only grows on a push, so almost_full can only rise after one
    af_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(almost_full) |-> $past(rd_req_valid || wr_req_valid))
        else begin error_count++; $error("almost_full rose without a push"); end

    // Nothing is issued in the cycle after the memory asks for back-pressure
    fiu_hold: assert property (@(posedge clk) disable iff (reset)
        fiu_almost_full |=> !fiu_rd_valid && !fiu_wr_valid)
        else begin error_count++; $error("Request issued under fiu_almost_full"); end

endmodule

bind wro_shim wro_shim_chk i_chk (.*);

// File: tests/wro_shim_tb.sv
// Random testbench with an out-of-order memory model. Relies on the pool addresses having distinct hashes
`timescale 1ns/1ps

module wro_shim_tb
    import wro_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int N_PAIRS         = 400;
    // Budget of 400 cycles for each request, both channels of every pair counted
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * N_PAIRS * 400;
    localparam int RD_TAG_W        = $bits(rd_tag_t);
    localparam int WR_TAG_W        = $bits(wr_tag_t);

    // One client request as it was sent
    typedef struct packed
    {
        addr_t       addr;
        mdata_t      mdata;
        logic        check_order;
        logic        same_addr;
        logic [15:0] pair_id;
    } sent_t;

    // Response the client should see, with the tag that it retires
    typedef struct packed
    {
        logic [7:0] tag;
        mdata_t     mdata;
    } exp_t;

    logic   clk;
    logic   reset;
    logic   rd_req_valid;
    addr_t  rd_req_addr;
    mdata_t rd_req_mdata;
    logic   rd_req_check_order;
    logic   wr_req_valid;
    addr_t  wr_req_addr;
    mdata_t wr_req_mdata;
    logic   wr_req_check_order;
    logic   almost_full;
    logic   rd_rsp_valid;
    mdata_t rd_rsp_mdata;
    logic   wr_rsp_valid;
    mdata_t wr_rsp_mdata;
    logic   fiu_rd_valid;
    addr_t  fiu_rd_addr;
    mdata_t fiu_rd_mdata;
    logic   fiu_wr_valid;
    addr_t  fiu_wr_addr;
    mdata_t fiu_wr_mdata;
    logic   fiu_almost_full;
    logic   fiu_rd_rsp_valid;
    mdata_t fiu_rd_rsp_mdata;
    logic   fiu_wr_rsp_valid;
    mdata_t fiu_wr_rsp_mdata;

    logic [31:0] lfsr;
    // Requests sent by the client and not yet seen at the memory port
    sent_t rd_sent_q[$];
    sent_t wr_sent_q[$];
    // Requests issued to memory, by tag, until the client gets the response
    sent_t rd_live [1 << RD_TAG_W];
    sent_t wr_live [1 << WR_TAG_W];
    logic [(1 << RD_TAG_W)-1:0] rd_live_valid;
    logic [(1 << WR_TAG_W)-1:0] wr_live_valid;
    logic [N_PAIRS-1:0] rd_issued_pair;
    // Memory model holds the issued mdata until it picks a request to answer
    mdata_t rd_mem_q[$];
    mdata_t wr_mem_q[$];
    exp_t   rd_exp_q[$];
    exp_t   wr_exp_q[$];
    int     pairs_sent;
    int     rd_total;
    int     wr_total;
    int     rd_done;
    int     wr_done;
    int     af_left;

    wro_shim i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Eight addresses that differ only in the lowest hash slice
    function automatic addr_t pool_addr(input logic [2:0] idx);
        return 32'h2468_0000 + (addr_t'(idx) << 6);
    endfunction

    // True if a live write, or a live read when asked, has this hash
    function automatic logic hash_live(input hash_t h, input logic check_reads);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < (1 << WR_TAG_W); i++)
        begin
            hit |= wr_live_valid[i] && (addr_hash(wr_live[i].addr) == h);
        end
        for (int i = 0; i < (1 << RD_TAG_W); i++)
        begin
            hit |= check_reads && rd_live_valid[i] && (addr_hash(rd_live[i].addr) == h);
        end
        return hit;
    endfunction

    // ====================
    // Issue and response checks

    // The oldest sent read must be the one that shows up, tag free and no write in the way
    task automatic accept_rd(output sent_t s);
        if (rd_sent_q.size() == 0)
        begin
            abort_run("A read reached the memory port that the client never sent");
        end
        s = rd_sent_q.pop_front();
        check_eq("fiu_rd_addr", fiu_rd_addr, s.addr);
        check_eq("fiu_rd_mdata upper", 32'(fiu_rd_mdata >> RD_TAG_W), 32'(s.mdata >> RD_TAG_W));
        if (rd_live_valid[fiu_rd_mdata[RD_TAG_W-1:0]])
        begin
            abort_run($sformatf("Read tag %0d reused at %0t while still outstanding",
                                fiu_rd_mdata[RD_TAG_W-1:0], $time));
        end
        if (s.check_order && hash_live(addr_hash(s.addr), 1'b0))
        begin
            abort_run($sformatf("Read to %0h issued at %0t past an outstanding write",
                                s.addr, $time));
        end
    endtask

    // A write must also wait for reads, and for its own read when both share an address
    task automatic accept_wr(output sent_t s);
        if (wr_sent_q.size() == 0)
        begin
            abort_run("A write reached the memory port that the client never sent");
        end
        s = wr_sent_q.pop_front();
        check_eq("fiu_wr_addr", fiu_wr_addr, s.addr);
        check_eq("fiu_wr_mdata upper", 32'(fiu_wr_mdata >> WR_TAG_W), 32'(s.mdata >> WR_TAG_W));
        if (wr_live_valid[fiu_wr_mdata[WR_TAG_W-1:0]])
        begin
            abort_run($sformatf("Write tag %0d reused at %0t while still outstanding",
                                fiu_wr_mdata[WR_TAG_W-1:0], $time));
        end
        if (s.check_order && hash_live(addr_hash(s.addr), 1'b1))
        begin
            abort_run($sformatf("Write to %0h issued at %0t past an outstanding request",
                                s.addr, $time));
        end
        if (s.same_addr && !rd_issued_pair[s.pair_id])
        begin
            abort_run($sformatf("Write of pair %0d issued before its read", s.pair_id));
        end
    endtask

    task automatic observe_dut();
        sent_t rd_s;
        sent_t wr_s;
        exp_t  e;
        // Both issues of one cycle are checked before either joins the live set
        if (fiu_rd_valid)
        begin
            accept_rd(rd_s);
        end
        if (fiu_wr_valid)
        begin
            accept_wr(wr_s);
        end
        if (fiu_rd_valid)
        begin
            rd_live[fiu_rd_mdata[RD_TAG_W-1:0]]       = rd_s;
            rd_live_valid[fiu_rd_mdata[RD_TAG_W-1:0]] = 1'b1;
            rd_issued_pair[rd_s.pair_id]              = 1'b1;
            rd_mem_q.push_back(fiu_rd_mdata);
        end
        if (fiu_wr_valid)
        begin
            wr_live[fiu_wr_mdata[WR_TAG_W-1:0]]       = wr_s;
            wr_live_valid[fiu_wr_mdata[WR_TAG_W-1:0]] = 1'b1;
            wr_mem_q.push_back(fiu_wr_mdata);
        end
        // Client responses come back in the order the memory model answered
        if (rd_rsp_valid)
        begin
            if (rd_exp_q.size() == 0)
            begin
                abort_run("A read response reached the client with none expected");
            end
            e = rd_exp_q.pop_front();
            check_eq("rd_rsp_mdata", rd_rsp_mdata, e.mdata);
            rd_live_valid[e.tag] = 1'b0;
            rd_done++;
        end
        if (wr_rsp_valid)
        begin
            if (wr_exp_q.size() == 0)
            begin
                abort_run("A write response reached the client with none expected");
            end
            e = wr_exp_q.pop_front();
            check_eq("wr_rsp_mdata", wr_rsp_mdata, e.mdata);
            wr_live_valid[e.tag] = 1'b0;
            wr_done++;
        end
        if (i_dut.i_chk.error_count != 0)
        begin
            abort_run("A bound assertion on the DUT failed");
        end
    endtask

    // ====================
    // Stimulus and memory model

    task automatic send_pair();
        sent_t r;
        sent_t w;
        logic  rd_on;
        logic  wr_on;
        rd_on = (take_bits(2) != 0);
        wr_on = (take_bits(2) != 0) || !rd_on;
        r.addr = pool_addr(3'(take_bits(3)));
        // A quarter of the pairs share one address on both channels
        w.addr = (take_bits(2) == 0) ? r.addr : pool_addr(3'(take_bits(3)));
        r.mdata = mdata_t'(take_bits(16));
        w.mdata = mdata_t'(take_bits(16));
        r.check_order = (take_bits(2) != 0);
        w.check_order = (take_bits(2) != 0);
        r.pair_id = 16'(pairs_sent);
        w.pair_id = 16'(pairs_sent);
        r.same_addr = rd_on && wr_on && (r.addr == w.addr);
        w.same_addr = r.same_addr;
        rd_req_valid       <= rd_on;
        rd_req_addr        <= r.addr;
        rd_req_mdata       <= r.mdata;
        rd_req_check_order <= r.check_order;
        wr_req_valid       <= wr_on;
        wr_req_addr        <= w.addr;
        wr_req_mdata       <= w.mdata;
        wr_req_check_order <= w.check_order;
        if (rd_on)
        begin
            rd_sent_q.push_back(r);
            rd_total++;
        end
        if (wr_on)
        begin
            wr_sent_q.push_back(w);
            wr_total++;
        end
        pairs_sent++;
    endtask

    task automatic drive_inputs();
        mdata_t m;
        int     idx;
        exp_t   e;
        // Memory answers a random outstanding request about every other cycle
        if (rd_mem_q.size() != 0 && take_bits(1) != 0)
        begin
            idx = int'(take_bits(8)) % rd_mem_q.size();
            m = rd_mem_q[idx];
            rd_mem_q.delete(idx);
            e.tag   = 8'(m[RD_TAG_W-1:0]);
            e.mdata = rd_live[m[RD_TAG_W-1:0]].mdata;
            rd_exp_q.push_back(e);
            fiu_rd_rsp_valid <= 1'b1;
            fiu_rd_rsp_mdata <= m;
        end
        else
        begin
            fiu_rd_rsp_valid <= 1'b0;
        end
        if (wr_mem_q.size() != 0 && take_bits(1) != 0)
        begin
            idx = int'(take_bits(8)) % wr_mem_q.size();
            m = wr_mem_q[idx];
            wr_mem_q.delete(idx);
            e.tag   = 8'(m[WR_TAG_W-1:0]);
            e.mdata = wr_live[m[WR_TAG_W-1:0]].mdata;
            wr_exp_q.push_back(e);
            fiu_wr_rsp_valid <= 1'b1;
            fiu_wr_rsp_mdata <= m;
        end
        else
        begin
            fiu_wr_rsp_valid <= 1'b0;
        end
        // Back-pressure stretches of up to 16 cycles
        if (af_left > 0)
        begin
            af_left--;
            fiu_almost_full <= 1'b1;
        end
        else if (take_bits(4) == 0)
        begin
            af_left = int'(take_bits(4));
            fiu_almost_full <= 1'b1;
        end
        else
        begin
            fiu_almost_full <= 1'b0;
        end
        // The client stays quiet after it sees almost_full
        if (pairs_sent < N_PAIRS && !almost_full && take_bits(1) != 0)
        begin
            send_pair();
        end
        else
        begin
            rd_req_valid <= 1'b0;
            wr_req_valid <= 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            observe_dut();
            drive_inputs();
        end
    end

    // ====================
    // Sequence and watchdog

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        lfsr = 32'hb1dcdd33;
        {rd_req_valid, rd_req_check_order, wr_req_valid, wr_req_check_order} = '0;
        {rd_req_addr, wr_req_addr, rd_req_mdata, wr_req_mdata} = '0;
        {fiu_almost_full, fiu_rd_rsp_valid, fiu_wr_rsp_valid} = '0;
        {fiu_rd_rsp_mdata, fiu_wr_rsp_mdata} = '0;
        {rd_live_valid, wr_live_valid, rd_issued_pair} = '0;
        {pairs_sent, rd_total, wr_total, rd_done, wr_done, af_left} = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        // Outputs are quiet while reset is held
        @(negedge clk);
        check_eq("almost_full", almost_full, 0);
        check_eq("fiu_rd_valid", fiu_rd_valid, 0);
        check_eq("fiu_wr_valid", fiu_wr_valid, 0);
        check_eq("rd_rsp_valid", rd_rsp_valid, 0);
        check_eq("wr_rsp_valid", wr_rsp_valid, 0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (!(pairs_sent == N_PAIRS && rd_done == rd_total && wr_done == wr_total))
        begin
            @(negedge clk);
        end
        // Idle tail so that a stray response would still be caught
        repeat (8) @(negedge clk);
        if (i_dut.i_chk.error_count != 0)
        begin
            abort_run("A bound assertion on the DUT failed near the end of the run");
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("Timeout: %0d of %0d reads and %0d of %0d writes answered",
                            rd_done, rd_total, wr_done, wr_total));
    end

endmodule

// File: wro_shim.f
+incdir+rtl
rtl/wro_pkg.sv
rtl/wro_req_fifo.sv
rtl/wro_filter_cam.sv
rtl/wro_tag_heap.sv
rtl/wro_order_ctrl.sv
rtl/wro_shim.sv
tests/wro_shim_chk.sv
tests/wro_shim_tb.sv
